//--- common/lane_dodge_pkg.sv
package lane_dodge_pkg;

    // basic value types
    typedef logic [9:0]  coord_t;
    typedef logic [1:0]  lane_t;
    typedef logic [11:0] rgb_t;
    typedef logic [15:0] score_t;

    typedef enum logic [1:0] {st_start, st_play, st_gameover} game_state_t;
    typedef enum logic {car_ready, car_moving} car_state_t;

    // 12-bit colors, r g b nibbles
    localparam rgb_t color_black = 12'h000;
    localparam rgb_t color_white = 12'hFFF;
    localparam rgb_t color_red   = 12'hF00;
    localparam rgb_t color_green = 12'h0F0;
    localparam rgb_t color_blue  = 12'h468;
    localparam rgb_t color_sand  = 12'hECA;

    // horizontal counter offset of the visible area
    localparam coord_t h_visible_start = 10'd144;

    // lane centers, screen x 180 / 320 / 460 shifted into counter space
    localparam coord_t lane_x_center_0 = h_visible_start + 10'd180;
    localparam coord_t lane_x_center_1 = h_visible_start + 10'd320;
    localparam coord_t lane_x_center_2 = h_visible_start + 10'd460;

    // playable water between the sand borders
    localparam coord_t sand_left  = h_visible_start + 10'd140;
    localparam coord_t sand_right = h_visible_start + 10'd500;

    // object geometry
    localparam coord_t player_y_start      = 10'd400;
    localparam coord_t player_height       = 10'd80;
    localparam coord_t player_half_width   = 10'd40;
    localparam coord_t obstacle_height     = 10'd80;
    localparam coord_t obstacle_half_width = 10'd40;
    localparam coord_t screen_bottom_y     = 10'd479;
    // rock fully off screen once its top passes this
    localparam coord_t obstacle_y_limit    = screen_bottom_y + obstacle_height;
    localparam coord_t obstacle0_y_init    = 10'd0;
    localparam coord_t obstacle1_y_init    = 10'd80;

    // pixels per game tick
    localparam coord_t obstacle_step = 10'd4;
    localparam coord_t car_step      = 10'd5;

    // starting lanes
    localparam lane_t obstacle0_lane_init = 2'd0;
    localparam lane_t obstacle1_lane_init = 2'd2;
    localparam lane_t player_lane_init    = 2'd1;

    localparam logic [7:0] lfsr_seed = 8'hAC;

    // lane index to x center, lane 3 is unused and folds to the middle
    function automatic coord_t lane_center(input lane_t lane);
        case (lane)
            2'd0:    return lane_x_center_0;
            2'd2:    return lane_x_center_2;
            default: return lane_x_center_1;
        endcase
    endfunction

endpackage

//--- rtl/button_debounce.sv
`timescale 1ns/1ps

module button_debounce #(
    parameter int debounce_cycles = 1000000
) (
    input  logic clk,
    input  logic rst_n,
    input  logic button,
    output logic pressed
);

    // hold counter, saturates at debounce_cycles
    logic [$clog2(debounce_cycles + 1)-1:0] count;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count   <= '0;
            pressed <= 1'b0;
        end else if (button) begin
            // keep counting while held
            if (count < debounce_cycles) begin
                count <= count + 1'b1;
            end else begin
                // held long enough
                pressed <= 1'b1;
            end
        end else begin
            // any release drops the output at once
            count   <= '0;
            pressed <= 1'b0;
        end
    end

endmodule

//--- rtl/game_timebase.sv
`timescale 1ns/1ps

module game_timebase
    import lane_dodge_pkg::*;
#(
    parameter int tick_cycles = 4194304
) (
    input  logic       clk,
    input  logic       rst_n,
    output logic       tick,
    output logic [7:0] lfsr
);

    // wrap counter for the slow game tick
    logic [$clog2(tick_cycles)-1:0] count;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
            tick  <= 1'b0;
        end else if (count == tick_cycles - 1) begin
            // end of period, one-cycle pulse
            count <= '0;
            tick  <= 1'b1;
        end else begin
            count <= count + 1'b1;
            tick  <= 1'b0;
        end
    end

    // fibonacci lfsr, x^8 + x^6 + 1
    // free running so lane picks depend on play timing
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lfsr <= lfsr_seed;
        end else begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5]};
        end
    end

endmodule

//--- game/player_ctrl.sv
`timescale 1ns/1ps

module player_ctrl
    import lane_dodge_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        tick,
    input  logic        btn_l,
    input  logic        btn_r,
    input  game_state_t state,
    output coord_t      car_x
);

    lane_t      lane;
    car_state_t car_state;
    coord_t     target_x;

    // where the boat should end up
    assign target_x = lane_center(lane);

    always_ff @(posedge clk) begin
        if (!rst_n || state == st_start) begin
            // middle lane, parked
            lane      <= player_lane_init;
            car_x     <= lane_center(player_lane_init);
            car_state <= car_ready;
        end else if (state == st_play) begin
            case (car_state)
                car_ready: begin
                    // locked to lane center while idle
                    car_x <= target_x;
                    // left wins if both held
                    if (btn_l && lane > 2'd0) begin
                        lane      <= lane - 2'd1;
                        car_state <= car_moving;
                    end else if (btn_r && lane < 2'd2) begin
                        lane      <= lane + 2'd1;
                        car_state <= car_moving;
                    end
                end
                car_moving: begin
                    // slide one step per game tick
                    if (tick) begin
                        if (car_x < target_x) begin
                            car_x <= car_x + car_step;
                        end else if (car_x > target_x) begin
                            car_x <= car_x - car_step;
                        end
                    end
                    // arrived, accept buttons again
                    if (car_x == target_x) begin
                        car_state <= car_ready;
                    end
                end
                default: begin
                    car_state <= car_ready;
                end
            endcase
        end
        // game over holds everything
    end

endmodule

//--- game/obstacle_field.sv
`timescale 1ns/1ps

module obstacle_field
    import lane_dodge_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        tick,
    input  game_state_t state,
    input  logic [7:0]  lfsr,
    output lane_t       obs_lane0,
    output lane_t       obs_lane1,
    output coord_t      obs_y0,
    output coord_t      obs_y1,
    output score_t      score
);

    logic  respawn0;
    logic  respawn1;
    lane_t next_lane0;
    lane_t next_lane1;

    // rock has left the bottom of the screen
    assign respawn0 = (obs_y0 >= obstacle_y_limit);
    assign respawn1 = (obs_y1 >= obstacle_y_limit);

    // fresh lanes from separate lfsr bit pairs, folded into 0..2
    assign next_lane0 = lane_t'(lfsr[1:0] % 2'd3);
    assign next_lane1 = lane_t'(lfsr[3:2] % 2'd3);

    always_ff @(posedge clk) begin
        if (!rst_n || state == st_start) begin
            // staggered start so the rocks do not arrive together
            obs_lane0 <= obstacle0_lane_init;
            obs_lane1 <= obstacle1_lane_init;
            obs_y0    <= obstacle0_y_init;
            obs_y1    <= obstacle1_y_init;
            score     <= '0;
        end else if (state == st_play && tick) begin
            // rock 0
            if (respawn0) begin
                obs_y0    <= '0;
                obs_lane0 <= next_lane0;
            end else begin
                obs_y0 <= obs_y0 + obstacle_step;
            end

            // rock 1
            if (respawn1) begin
                obs_y1    <= '0;
                obs_lane1 <= next_lane1;
            end else begin
                obs_y1 <= obs_y1 + obstacle_step;
            end

            // one point per dodged rock, two if both cleared this tick
            score <= score + score_t'(respawn0) + score_t'(respawn1);
        end
        // frozen in game over
    end

endmodule

//--- game/game_fsm.sv
`timescale 1ns/1ps

module game_fsm
    import lane_dodge_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        btn_c,
    input  coord_t      car_x,
    input  lane_t       obs_lane0,
    input  lane_t       obs_lane1,
    input  coord_t      obs_y0,
    input  coord_t      obs_y1,
    output game_state_t state,
    output logic        collision
);

    coord_t p_x0, p_x1, p_y1;
    coord_t o0_x, o1_x;
    logic   hit0, hit1;

    // boat box edges
    assign p_x0 = car_x - player_half_width;
    assign p_x1 = car_x + player_half_width;
    assign p_y1 = player_y_start + player_height;

    assign o0_x = lane_center(obs_lane0);
    assign o1_x = lane_center(obs_lane1);

    // inclusive edges, touching counts as a hit
    assign hit0 = (p_x1 >= o0_x - obstacle_half_width) &&
                  (p_x0 <= o0_x + obstacle_half_width) &&
                  (p_y1 >= obs_y0) && (player_y_start <= obs_y0 + obstacle_height);
    assign hit1 = (p_x1 >= o1_x - obstacle_half_width) &&
                  (p_x0 <= o1_x + obstacle_half_width) &&
                  (p_y1 >= obs_y1) && (player_y_start <= obs_y1 + obstacle_height);
    assign collision = hit0 || hit1;

    // st_start is the one-cycle restart, other blocks reload on it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_play;
        end else begin
            case (state)
                st_start:    state <= st_play;
                // center beats collision
                st_play:     state <= btn_c ? st_start : (collision ? st_gameover : st_play);
                st_gameover: state <= btn_c ? st_start : st_gameover;
                default:     state <= st_start;
            endcase
        end
    end

endmodule

//--- rtl/pixel_render.sv
`timescale 1ns/1ps

module pixel_render
    import lane_dodge_pkg::*;
(
    input  logic        bright,
    input  coord_t      h_count,
    input  coord_t      v_count,
    input  coord_t      car_x,
    input  lane_t       obs_lane0,
    input  lane_t       obs_lane1,
    input  coord_t      obs_y0,
    input  coord_t      obs_y1,
    input  game_state_t state,
    input  logic        collision,
    output rgb_t        rgb
);

    coord_t obs0_x;
    coord_t obs1_x;
    logic   in_boat;
    logic   in_rock0;
    logic   in_rock1;
    logic   in_rock;
    logic   in_sand;

    // rock centers from their lanes
    assign obs0_x = lane_center(obs_lane0);
    assign obs1_x = lane_center(obs_lane1);

    // boat box, half-open on both axes
    assign in_boat = (h_count >= car_x - player_half_width) &&
                     (h_count <  car_x + player_half_width) &&
                     (v_count >= player_y_start) &&
                     (v_count <  player_y_start + player_height);

    // rock boxes, top edge at obs_y
    assign in_rock0 = (h_count >= obs0_x - obstacle_half_width) &&
                      (h_count <  obs0_x + obstacle_half_width) &&
                      (v_count >= obs_y0) &&
                      (v_count <  obs_y0 + obstacle_height);
    assign in_rock1 = (h_count >= obs1_x - obstacle_half_width) &&
                      (h_count <  obs1_x + obstacle_half_width) &&
                      (v_count >= obs_y1) &&
                      (v_count <  obs_y1 + obstacle_height);
    assign in_rock  = in_rock0 || in_rock1;

    // borders left and right of the three lanes
    assign in_sand = (h_count < sand_left) || (h_count >= sand_right);

    always_comb begin
        if (!bright) begin
            // blanking
            rgb = color_black;
        end else if (state == st_gameover && collision) begin
            // crash frame, everything solid turns red
            if (in_boat || in_rock) rgb = color_red;
            else if (in_sand)       rgb = color_sand;
            else                    rgb = color_blue;
        end else if (in_sand) begin
            rgb = color_sand;
        end else if (in_boat) begin
            // boat drawn over rocks
            rgb = color_white;
        end else if (in_rock) begin
            rgb = color_green;
        end else begin
            // open water
            rgb = color_blue;
        end
    end

endmodule

//--- rtl/lane_dodge_top.sv
`timescale 1ns/1ps

module lane_dodge_top
    import lane_dodge_pkg::*;
#(
    parameter int debounce_cycles = 1000000,
    parameter int tick_cycles     = 4194304
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   bright,
    input  logic   button_l,
    input  logic   button_r,
    input  logic   button_c,
    input  coord_t h_count,
    input  coord_t v_count,
    output rgb_t   rgb,
    output score_t score
);

    // debounced buttons
    logic btn_l;
    logic btn_r;
    logic btn_c;

    // timebase
    logic       tick;
    logic [7:0] lfsr;

    // game state shared by all blocks
    game_state_t state;
    logic        collision;
    coord_t      car_x;
    lane_t       obs_lane0;
    lane_t       obs_lane1;
    coord_t      obs_y0;
    coord_t      obs_y1;

    button_debounce #(.debounce_cycles(debounce_cycles)) i_deb_l (
        .clk(clk), .rst_n(rst_n), .button(button_l), .pressed(btn_l)
    );
    button_debounce #(.debounce_cycles(debounce_cycles)) i_deb_r (
        .clk(clk), .rst_n(rst_n), .button(button_r), .pressed(btn_r)
    );
    button_debounce #(.debounce_cycles(debounce_cycles)) i_deb_c (
        .clk(clk), .rst_n(rst_n), .button(button_c), .pressed(btn_c)
    );

    game_timebase #(.tick_cycles(tick_cycles)) i_timebase (
        .clk(clk), .rst_n(rst_n), .tick(tick), .lfsr(lfsr)
    );

    player_ctrl i_player (
        .clk(clk), .rst_n(rst_n), .tick(tick), .btn_l(btn_l), .btn_r(btn_r),
        .state(state), .car_x(car_x)
    );

    obstacle_field i_obstacles (
        .clk(clk), .rst_n(rst_n), .tick(tick), .state(state), .lfsr(lfsr),
        .obs_lane0(obs_lane0), .obs_lane1(obs_lane1),
        .obs_y0(obs_y0), .obs_y1(obs_y1), .score(score)
    );

    game_fsm i_fsm (
        .clk(clk), .rst_n(rst_n), .btn_c(btn_c), .car_x(car_x),
        .obs_lane0(obs_lane0), .obs_lane1(obs_lane1),
        .obs_y0(obs_y0), .obs_y1(obs_y1), .state(state), .collision(collision)
    );

    pixel_render i_render (
        .bright(bright), .h_count(h_count), .v_count(v_count), .car_x(car_x),
        .obs_lane0(obs_lane0), .obs_lane1(obs_lane1),
        .obs_y0(obs_y0), .obs_y1(obs_y1),
        .state(state), .collision(collision), .rgb(rgb)
    );

endmodule

//--- tests/lane_dodge_sva.sv
`timescale 1ns/1ps

module lane_dodge_sva
    import lane_dodge_pkg::*;
(
    input logic   clk,
    input logic   rst_n,
    input logic   bright,
    input logic   tick,
    input logic   btn_c,
    input rgb_t   rgb,
    input score_t score
);

    // failures seen so far, read by the testbench
    int unsigned error_count;

    initial error_count = 0;

    // nothing drawn during blanking
    blank_is_black: assert property (@(posedge clk) disable iff (!rst_n)
        !bright |-> rgb == color_black)
        else begin
            error_count++;
            $error("rgb not black while bright is low");
        end

    // at most two rocks respawn per tick, restart clears
    score_steps: assert property (@(posedge clk) disable iff (!rst_n)
        1'b1 |=> (score == $past(score) || score == $past(score) + score_t'(1) ||
                  score == $past(score) + score_t'(2) || score == '0))
        else begin
            error_count++;
            $error("score moved by more than two");
        end

    // st_start follows a center press by one cycle
    score_holds: assert property (@(posedge clk) disable iff (!rst_n)
        (!tick && !$past(btn_c)) |=> $stable(score))
        else begin
            error_count++;
            $error("score changed without a tick or a restart");
        end

endmodule

bind lane_dodge_top lane_dodge_sva i_sva (
    .clk(clk), .rst_n(rst_n), .bright(bright), .tick(tick), .btn_c(btn_c),
    .rgb(rgb), .score(score)
);

//--- tests/tb_lane_dodge.sv
`timescale 1ns/1ps

module tb_lane_dodge
    import lane_dodge_pkg::*;
();

    localparam int tick_len  = 16;
    localparam int probes    = 4;
    localparam int chk_rgb   = 0;
    localparam int chk_score = 1;

    // one table row
    // buttons held first, then waits, then one check
    typedef struct packed {
        logic [2:0] btns;
        int         hold;
        int         cycles;
        int         ticks;
        int         kind;
        logic       bright;
        int         x_lo;
        int         x_hi;
        int         y_lo;
        int         y_hi;
        int         exp_val;
    } step_t;

    logic   clk;
    logic   rst_n;
    logic   bright;
    logic   button_l;
    logic   button_r;
    logic   button_c;
    coord_t h_count;
    coord_t v_count;
    rgb_t   rgb;
    score_t score;

    step_t steps[$];
    int    seed         = 32'h0dc3fae6;
    int    cycle_count  = 0;
    int    limit_cycles = 0;

    lane_dodge_top #(.debounce_cycles(8), .tick_cycles(tick_len)) i_dut (
        .clk(clk), .rst_n(rst_n), .bright(bright), .button_l(button_l),
        .button_r(button_r), .button_c(button_c), .h_count(h_count),
        .v_count(v_count), .rgb(rgb), .score(score)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic push_step(input logic [2:0] btns, input int hold, input int cycles,
                             input int ticks, input int kind, input logic b,
                             input int x_lo, input int x_hi, input int y_lo,
                             input int y_hi, input int exp_val);
        step_t s;
        s = '{btns, hold, cycles, ticks, kind, b, x_lo, x_hi, y_lo, y_hi, exp_val};
        steps.push_back(s);
    endtask

    // boat in lane 1, rock 0 lane 0 at top, rock 1 lane 2 at Y 80
    task automatic push_start_scene();
        push_step(3'b000,  0, 0,   0, chk_rgb,   1'b1, 430, 497, 405, 475, color_white);
        push_step(3'b000,  0, 0,   0, chk_rgb,   1'b1, 290, 357,  16,  70, color_green);
        push_step(3'b000,  0, 0,   0, chk_rgb,   1'b1, 570, 637,  96, 150, color_green);
        push_step(3'b000,  0, 0,   0, chk_rgb,   1'b1, 370, 555,   0, 390, color_blue);
        push_step(3'b000,  0, 0,   0, chk_rgb,   1'b1, 290, 357, 100, 470, color_blue);
    endtask

    task automatic build_table();
        push_start_scene();
        push_step(3'b000,  0, 0,   0, chk_score, 1'b1,   0,   0,   0,   0, 0);
        // blanking, then sand on both borders
        push_step(3'b000,  0, 0,   0, chk_rgb,   1'b0,   0, 799,   0, 524, color_black);
        push_step(3'b000,  0, 0,   0, chk_rgb,   1'b1, 150, 283,   0, 479, color_sand);
        push_step(3'b000,  0, 0,   0, chk_rgb,   1'b1, 644, 783,   0, 479, color_sand);
        // rock 1 respawns at tick 121, rock 0 at tick 141
        push_step(3'b000,  0, 0, 128, chk_score, 1'b1,   0,   0,   0,   0, 1);
        push_step(3'b000,  0, 0,  15, chk_score, 1'b1,   0,   0,   0,   0, 2);
        // center press restarts
        push_step(3'b001, 12, 2,   0, chk_score, 1'b1,   0,   0,   0,   0, 0);
        push_start_scene();
        // slide right into lane 2 over 28 ticks
        push_step(3'b010, 12, 0,  35, chk_rgb,   1'b1, 570, 637, 405, 475, color_white);
        push_step(3'b000,  0, 0,   0, chk_rgb,   1'b1, 430, 497, 405, 475, color_blue);
        // rock 1 meets the boat at tick 60
        push_step(3'b000,  0, 0,  35, chk_rgb,   1'b1, 570, 637, 405, 475, color_red);
        push_step(3'b000,  0, 0,   0, chk_rgb,   1'b1, 570, 637, 330, 390, color_red);
        push_step(3'b000,  0, 0,   0, chk_rgb,   1'b1, 370, 555,   0, 479, color_blue);
        push_step(3'b000,  0, 0,   0, chk_score, 1'b1,   0,   0,   0,   0, 0);
        // out of game over with the lane 2 bottom clear again
        push_step(3'b001, 12, 2,   0, chk_rgb,   1'b1, 570, 637, 405, 475, color_blue);
        push_start_scene();
    endtask

    // worst case cycles for the whole table plus a quarter
    function automatic int run_budget();
        int total;
        total = 4;
        foreach (steps[i]) begin
            total += steps[i].hold + steps[i].cycles + steps[i].ticks * tick_len;
            total += probes + 2;
        end
        return total + total / 4;
    endfunction

    function automatic int pick(input int lo, input int hi);
        int unsigned r;
        r = $random(seed);
        return lo + int'(r % (hi - lo + 1));
    endfunction

    task automatic check_rgb(input rgb_t expected, input rgb_t actual, input int idx);
        if (actual !== expected) begin
            $display("[ERROR] %0t: step %0d rgb at (%0d,%0d) expected %h, got %h",
                     $time, idx, h_count, v_count, expected, actual);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic check_score(input score_t expected, input score_t actual, input int idx);
        if (actual !== expected) begin
            $display("[ERROR] %0t: step %0d score expected %0d, got %0d",
                     $time, idx, expected, actual);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    // count one-cycle game ticks
    task automatic wait_ticks(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(negedge clk);
            if (i_dut.tick) seen++;
        end
    endtask

    task automatic run_step(input int idx);
        step_t s;
        s = steps[idx];
        if (s.hold > 0) begin
            @(posedge clk);
            button_l <= s.btns[2];
            button_r <= s.btns[1];
            button_c <= s.btns[0];
            repeat (s.hold) @(posedge clk);
            button_l <= 1'b0;
            button_r <= 1'b0;
            button_c <= 1'b0;
        end
        repeat (s.cycles) @(posedge clk);
        wait_ticks(s.ticks);
        if (s.kind == chk_score) begin
            @(negedge clk);
            check_score(score_t'(s.exp_val), score, idx);
        end else begin
            // random pixels inside the region
            for (int p = 0; p < probes; p++) begin
                @(posedge clk);
                bright  <= s.bright;
                h_count <= coord_t'(pick(s.x_lo, s.x_hi));
                v_count <= coord_t'(pick(s.y_lo, s.y_hi));
                @(negedge clk);
                check_rgb(rgb_t'(s.exp_val), rgb, idx);
            end
        end
    endtask

    // watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (limit_cycles > 0 && cycle_count > limit_cycles) begin
            $display("timeout, the table did not finish within %0d cycles", limit_cycles);
            $display("tests failed");
            $fatal(1);
        end
    end

    always @(negedge clk) begin
        if (i_dut.i_sva.error_count != 0) begin
            $display("a bound assertion on the DUT failed");
            $display("tests failed");
            $fatal(1);
        end
    end

    initial begin
        rst_n    = 1'b0;
        bright   = 1'b0;
        button_l = 1'b0;
        button_r = 1'b0;
        button_c = 1'b0;
        h_count  = '0;
        v_count  = '0;
        build_table();
        limit_cycles = run_budget();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < steps.size(); i++) begin
            run_step(i);
        end
        @(negedge clk);
        if (i_dut.i_sva.error_count != 0) begin
            $display("tests failed");
            $fatal(1);
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

//--- lane_dodge.f
common/lane_dodge_pkg.sv
rtl/button_debounce.sv
rtl/game_timebase.sv
game/player_ctrl.sv
game/obstacle_field.sv
game/game_fsm.sv
rtl/pixel_render.sv
rtl/lane_dodge_top.sv
tests/lane_dodge_sva.sv
tests/tb_lane_dodge.sv

//--- Bender.yml
package:
  name: lane_dodge

sources:
  # package first, then leaf blocks, then the top level
  - common/lane_dodge_pkg.sv
  - rtl/button_debounce.sv
  - rtl/game_timebase.sv
  - game/player_ctrl.sv
  - game/obstacle_field.sv
  - game/game_fsm.sv
  - rtl/pixel_render.sv
  - rtl/lane_dodge_top.sv

  # simulation only
  - target: test
    files:
      - tests/lane_dodge_sva.sv
      - tests/tb_lane_dodge.sv
